//--- logic/periph_pkg.sv
package periph_pkg;

    // fast clock rate in Hz, also the tone divider dividend.
    localparam logic [31:0] clk_freq = 32'd50_000_000;

    localparam int data_w = 32;

    // peripheral select, taken from address bits 5:4.
    localparam logic [1:0] sel_buzzer = 2'd0;
    localparam logic [1:0] sel_led    = 2'd1;

    // buzzer word indices, address bits 3:2.
    localparam logic [1:0] reg_ctrl = 2'd0;
    localparam logic [1:0] reg_freq = 2'd1;
    localparam logic [1:0] reg_dur  = 2'd2;

    // led word indices.
    localparam logic [1:0] reg_led_data = 2'd0;
    localparam logic [1:0] reg_led_set  = 2'd1;
    localparam logic [1:0] reg_led_clr  = 2'd2;

    localparam int led_w = 16;

    // one quotient bit per iteration.
    localparam int div_steps = 32;

endpackage

//--- logic/periph_bus.sv
module periph_bus (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          clk_cpu,
    input  logic [29:0]                   addr,
    input  logic                          we,
    output logic                          wr_buzzer,
    output logic                          wr_led,
    output logic [1:0]                    reg_idx,
    input  logic [periph_pkg::data_w-1:0] rdata_buzzer,
    input  logic [periph_pkg::data_w-1:0] rdata_led,
    output logic [periph_pkg::data_w-1:0] rdata
);

    logic       clk_cpu_q;
    logic       wr_edge;
    logic [1:0] sel;

    // previous level of the cpu clock, sampled in the fast domain.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_cpu_q <= 1'b0;
        end else begin
            clk_cpu_q <= clk_cpu;
        end
    end

    // a write lands once, on the first fast cycle after clk_cpu rises.
    assign wr_edge = we && clk_cpu && !clk_cpu_q;

    // addr holds word address bits 31:2, so bits 5:4 sit at 3:2 here.
    assign sel     = addr[3:2];
    assign reg_idx = addr[1:0];

    assign wr_buzzer = wr_edge && (sel == periph_pkg::sel_buzzer);
    assign wr_led    = wr_edge && (sel == periph_pkg::sel_led);

    always_comb begin
        case (sel)
            periph_pkg::sel_buzzer: rdata = rdata_buzzer;
            periph_pkg::sel_led:    rdata = rdata_led;
            default:                rdata = '0;
        endcase
    end

endmodule

//--- logic/tone_divider.sv
module tone_divider (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [periph_pkg::data_w-1:0] dividend,
    input  logic [periph_pkg::data_w-1:0] divisor,
    output logic                          busy,
    output logic [periph_pkg::data_w-1:0] quotient
);

    logic [$clog2(periph_pkg::div_steps)-1:0] step_cnt;
    logic [periph_pkg::data_w-1:0]            div_q;
    logic [periph_pkg::data_w-1:0]            rem_q;
    logic [periph_pkg::data_w-1:0]            divisor_q;
    logic [periph_pkg::data_w:0]              trial;
    logic [periph_pkg::data_w:0]              diff;
    logic                                     fits;

    // shift the next dividend bit into the partial remainder and try a subtract.
    assign trial = {rem_q, div_q[periph_pkg::data_w-1]};
    assign diff  = trial - {1'b0, divisor_q};
    assign fits  = !diff[periph_pkg::data_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            div_q    <= '0;
        end else if (start) begin
            step_cnt <= '0;
            if (divisor == '0) begin
                // a zero divisor gives a zero quotient without iterating.
                busy  <= 1'b0;
                div_q <= '0;
            end else begin
                busy  <= 1'b1;
                div_q <= dividend;
            end
        end else if (busy) begin
            div_q    <= {div_q[periph_pkg::data_w-2:0], fits};
            step_cnt <= step_cnt + 1'b1;
            if (int'(step_cnt) == periph_pkg::div_steps - 1) begin
                busy <= 1'b0;
            end
        end
    end

    // partial remainder and the divisor latched at start.
    always_ff @(posedge clk) begin
        if (start) begin
            rem_q     <= '0;
            divisor_q <= divisor;
        end else if (busy && fits) begin
            rem_q <= diff[periph_pkg::data_w-1:0];
        end else if (busy) begin
            rem_q <= trial[periph_pkg::data_w-1:0];
        end
    end

    // dividend bits have all shifted out by the time busy falls.
    assign quotient = div_q;

endmodule

//--- logic/buzzer.sv
module buzzer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr,
    input  logic [1:0]                    reg_idx,
    input  logic [periph_pkg::data_w-1:0] wdata,
    output logic [periph_pkg::data_w-1:0] rdata,
    output logic                          buzz
);

    typedef enum logic {
        st_idle,
        st_run
    } state_t;

    state_t                        state;
    logic                          ctrl_en;
    logic [periph_pkg::data_w-1:0] freq;
    logic [periph_pkg::data_w-1:0] dur;
    logic [periph_pkg::data_w-1:0] dur_cnt;
    logic [periph_pkg::data_w-1:0] per_cnt;
    logic [periph_pkg::data_w-1:0] per_reload;
    logic [periph_pkg::data_w-1:0] half_period;
    logic                          div_start;
    logic                          div_busy;

    tone_divider u_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (div_start),
        .dividend (periph_pkg::clk_freq),
        .divisor  (freq),
        .busy     (div_busy),
        .quotient (half_period)
    );

    // start the divider the cycle after freq takes its new value.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_start <= 1'b0;
        end else begin
            div_start <= wr && (reg_idx == periph_pkg::reg_freq);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_en    <= 1'b0;
            freq       <= '0;
            dur        <= '0;
            dur_cnt    <= '0;
            per_cnt    <= '0;
            per_reload <= '0;
            buzz       <= 1'b0;
            state      <= st_idle;
        end else if (wr) begin
            // a bus write holds the note machine for this cycle.
            case (reg_idx)
                periph_pkg::reg_ctrl: ctrl_en <= wdata[0];
                periph_pkg::reg_freq: freq    <= wdata;
                periph_pkg::reg_dur:  dur     <= wdata;
                default: ;
            endcase
        end else begin
            case (state)
                st_idle: begin
                    if (ctrl_en && !div_busy && !div_start && half_period != '0) begin
                        dur_cnt    <= dur;
                        per_cnt    <= half_period;
                        per_reload <= half_period;
                        state      <= st_run;
                    end
                end
                st_run: begin
                    if (!ctrl_en) begin
                        dur_cnt <= '0;
                        per_cnt <= '0;
                        state   <= st_idle;
                    end else if (dur_cnt > 1) begin
                        dur_cnt <= dur_cnt - 1'b1;
                        if (per_cnt != '0) begin
                            per_cnt <= per_cnt - 1'b1;
                        end else begin
                            per_cnt <= per_reload;
                            buzz    <= ~buzz;
                        end
                    end else begin
                        // note done, enable drops by itself.
                        dur_cnt <= '0;
                        per_cnt <= '0;
                        ctrl_en <= 1'b0;
                        state   <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_comb begin
        case (reg_idx)
            periph_pkg::reg_ctrl: rdata = {{(periph_pkg::data_w-1){1'b0}}, ctrl_en};
            periph_pkg::reg_freq: rdata = freq;
            periph_pkg::reg_dur:  rdata = dur;
            default:              rdata = '0;
        endcase
    end

endmodule

//--- logic/led_port.sv
module led_port (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr,
    input  logic [1:0]                    reg_idx,
    input  logic [periph_pkg::data_w-1:0] wdata,
    output logic [periph_pkg::data_w-1:0] rdata,
    output logic [periph_pkg::led_w-1:0]  leds
);

    logic [periph_pkg::led_w-1:0] mask;

    // only the low bits of the bus word reach the leds.
    assign mask = wdata[periph_pkg::led_w-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            leds <= '0;
        end else if (wr) begin
            case (reg_idx)
                periph_pkg::reg_led_data: leds <= mask;
                periph_pkg::reg_led_set:  leds <= leds | mask;
                periph_pkg::reg_led_clr:  leds <= leds & ~mask;
                default: ;
            endcase
        end
    end

    // every index reads the current pattern.
    assign rdata = {{(periph_pkg::data_w-periph_pkg::led_w){1'b0}}, leds};

endmodule

//--- logic/periph_top.sv
module periph_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          clk_cpu,
    input  logic [29:0]                   addr,
    input  logic [periph_pkg::data_w-1:0] wdata,
    input  logic                          we,
    output logic [periph_pkg::data_w-1:0] rdata,
    output logic                          buzz,
    output logic [periph_pkg::led_w-1:0]  leds
);

    logic                          wr_buzzer;
    logic                          wr_led;
    logic [1:0]                    reg_idx;
    logic [periph_pkg::data_w-1:0] rdata_buzzer;
    logic [periph_pkg::data_w-1:0] rdata_led;

    periph_bus u_bus (
        .clk          (clk),
        .rst_n        (rst_n),
        .clk_cpu      (clk_cpu),
        .addr         (addr),
        .we           (we),
        .wr_buzzer    (wr_buzzer),
        .wr_led       (wr_led),
        .reg_idx      (reg_idx),
        .rdata_buzzer (rdata_buzzer),
        .rdata_led    (rdata_led),
        .rdata        (rdata)
    );

    // wdata goes straight to both peripherals.
    buzzer u_buzzer (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr_buzzer),
        .reg_idx (reg_idx),
        .wdata   (wdata),
        .rdata   (rdata_buzzer),
        .buzz    (buzz)
    );

    led_port u_led (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr_led),
        .reg_idx (reg_idx),
        .wdata   (wdata),
        .rdata   (rdata_led),
        .leds    (leds)
    );

endmodule

//--- verif/periph_checker.sv
module periph_checker (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [periph_pkg::data_w-1:0] rdata,
    input  logic                          buzz,
    input  logic [periph_pkg::led_w-1:0]  leds,
    input  logic                          check_req,
    input  logic [7:0]                    check_kind,
    input  logic [31:0]                   check_val,
    output int                            read_errs,
    output int                            led_errs,
    output int                            note_errs
);

    timeunit 1ns;
    timeprecision 100ps;

    logic req_seen;
    logic buzz_q;
    int   toggles;

    initial begin
        read_errs = 0;
        led_errs  = 0;
        note_errs = 0;
        req_seen  = 1'b0;
        buzz_q    = 1'b0;
        toggles   = 0;
    end

    task automatic compare(input logic [7:0] kind, input logic [31:0] expected);
        case (kind)
            "R": begin
                if (rdata !== expected) begin
                    $display("Error at %0d ns: rdata expected %h, got %h",
                             $time, expected, rdata);
                    read_errs++;
                end
            end
            "L": begin
                if (leds !== expected[periph_pkg::led_w-1:0]) begin
                    $display("Error at %0d ns: leds expected %h, got %h",
                             $time, expected[periph_pkg::led_w-1:0], leds);
                    led_errs++;
                end
            end
            "N": begin
                if (toggles != int'(expected)) begin
                    $display("Error at %0d ns: buzz toggles expected %0d, got %0d",
                             $time, expected, toggles);
                    note_errs++;
                end
                toggles = 0;
            end
            "M": begin
                if (toggles > int'(expected)) begin
                    $display("Error at %0d ns: buzz toggles expected at most %0d, got %0d",
                             $time, expected, toggles);
                    note_errs++;
                end
                toggles = 0;
            end
            default: ;
        endcase
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            buzz_q  = buzz;
            toggles = 0;
        end else if (buzz !== buzz_q) begin
            buzz_q  = buzz;
            toggles = toggles + 1;
        end
        // the driver flips check_req once per expected value.
        if (check_req !== req_seen) begin
            req_seen = check_req;
            compare(check_kind, check_val);
        end
    end

endmodule

//--- verif/periph_sva.sv
module periph_sva (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         wr_buzzer,
    input logic                         wr_led,
    input logic                         running,
    input logic                         div_busy,
    input logic                         buzz,
    input logic [periph_pkg::led_w-1:0] leds
);

    timeunit 1ns;
    timeprecision 100ps;

    int fails = 0;

    strobe_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_buzzer || wr_led) |=> !(wr_buzzer || wr_led))
        else begin
            fails++;
            $error("write strobe held for more than one cycle");
        end

    strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_buzzer && wr_led))
        else begin
            fails++;
            $error("buzzer and led strobes high together");
        end

    // buzz only moves while a note runs.
    buzz_idle_stable: assert property (@(posedge clk) disable iff (!rst_n)
        !running |=> $stable(buzz))
        else begin
            fails++;
            $error("buzz changed while the buzzer was idle");
        end

    busy_length: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(div_busy) |-> ##(periph_pkg::div_steps) $fell(div_busy))
        else begin
            fails++;
            $error("divider busy did not last the expected number of cycles");
        end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!buzz && leds == '0 && !wr_buzzer && !wr_led && !div_busy))
        else begin
            fails++;
            $error("outputs not cleared during reset");
        end

endmodule

bind periph_top periph_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_buzzer (wr_buzzer),
    .wr_led    (wr_led),
    .running   (u_buzzer.state),
    .div_busy  (u_buzzer.div_busy),
    .buzz      (buzz),
    .leds      (leds)
);

//--- verif/periph_tb.sv
module periph_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                          clk;
    logic                          rst_n;
    logic                          clk_cpu;
    logic [29:0]                   addr;
    logic [periph_pkg::data_w-1:0] wdata;
    logic                          we;
    logic [periph_pkg::data_w-1:0] rdata;
    logic                          buzz;
    logic [periph_pkg::led_w-1:0]  leds;

    logic        check_req;
    logic [7:0]  check_kind;
    logic [31:0] check_val;
    int          read_errs;
    int          led_errs;
    int          note_errs;
    int          file_errs;
    int          total_errs;
    int          limit_cycles;
    bit          file_ok;

    logic [7:0]  op_kind [$];
    logic [31:0] op_a [$];
    logic [31:0] op_b [$];

    periph_top uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .clk_cpu (clk_cpu),
        .addr    (addr),
        .wdata   (wdata),
        .we      (we),
        .rdata   (rdata),
        .buzz    (buzz),
        .leds    (leds)
    );

    periph_checker u_check (
        .clk        (clk),
        .rst_n      (rst_n),
        .rdata      (uut.rdata),
        .buzz       (uut.buzz),
        .leds       (uut.leds),
        .check_req  (check_req),
        .check_kind (check_kind),
        .check_val  (check_val),
        .read_errs  (read_errs),
        .led_errs   (led_errs),
        .note_errs  (note_errs)
    );

    // each line is an op letter and one or two values.
    task automatic load_tests();
        int               fd;
        int               n;
        int               want;
        int               limit;
        logic [7:0]       kind;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [8*128-1:0] rest;
        fd = $fopen("verif/periph_tests.txt", "r");
        file_ok = (fd != 0);
        limit = 200;
        if (file_ok) begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                a = '0;
                b = '0;
                if (kind == "#") begin
                    n = $fgets(rest, fd);
                end else begin
                    if (kind == "W" || kind == "H" || kind == "R") begin
                        n = $fscanf(fd, " %h %h", a, b);
                        want = 2;
                    end else if (kind == "L") begin
                        n = $fscanf(fd, " %h", a);
                        want = 1;
                    end else begin
                        n = $fscanf(fd, " %d", a);
                        want = 1;
                    end
                    if (n != want) begin
                        $display("malformed %c line in the tests file", kind);
                        file_errs++;
                    end
                    op_kind.push_back(kind);
                    op_a.push_back(a);
                    op_b.push_back(b);
                    limit = limit + 40;
                    if (kind == "D") begin
                        limit = limit + int'(a);
                    end
                end
            end
            $fclose(fd);
        end
        limit_cycles = limit;
    endtask

    // hand one expected value to the checker, which takes it at the next rising edge.
    task automatic send_check(input logic [7:0] kind, input logic [31:0] value);
        check_kind = kind;
        check_val  = value;
        check_req  = ~check_req;
        @(negedge clk);
    endtask

    task automatic bus_write(input logic [29:0] a, input logic [31:0] d, input int hold);
        addr  = a;
        wdata = d;
        we    = 1'b1;
        @(negedge clk);
        clk_cpu = 1'b1;
        if (hold > 0) begin
            // a second strobe would now latch the inverted word.
            repeat (4) @(negedge clk);
            wdata = ~d;
        end
        repeat (2 + hold) @(negedge clk);
        clk_cpu = 1'b0;
        repeat (2) @(negedge clk);
        we = 1'b0;
    endtask

    task automatic run_op(input logic [7:0] kind, input logic [31:0] a, input logic [31:0] b);
        case (kind)
            "W": bus_write(a[29:0], b, 0);
            "H": bus_write(a[29:0], b, 16);
            "R": begin
                addr = a[29:0];
                send_check(kind, b);
            end
            "D": repeat (a) @(negedge clk);
            "N", "M", "L": send_check(kind, a);
            default: begin
                $display("unknown operation %c in the tests file", kind);
                file_errs++;
            end
        endcase
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        clk_cpu      = 1'b0;
        addr         = '0;
        wdata        = '0;
        we           = 1'b0;
        check_req    = 1'b0;
        check_kind   = '0;
        check_val    = '0;
        file_errs    = 0;
        limit_cycles = 0;
        load_tests();
        if (!file_ok) begin
            $display("could not open verif/periph_tests.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            repeat (16) @(negedge clk);
            rst_n = 1'b1;
            @(negedge clk);
            foreach (op_kind[i]) begin
                run_op(op_kind[i], op_a[i], op_b[i]);
            end
            repeat (4) @(negedge clk);
            total_errs = read_errs + led_errs + note_errs + file_errs + uut.u_sva.fails;
            $display("errors: read %0d, leds %0d, notes %0d, test file %0d, assertions %0d",
                     read_errs, led_errs, note_errs, file_errs, uut.u_sva.fails);
            if (total_errs == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

//--- verif/periph_tests.txt
# W/H word-addr data: write (H holds clk_cpu high), R word-addr data: read and expect
# D cycles: wait, N count: exact buzz toggles, M count: at most, L hex: expected leds
W 1 004c4b40
R 1 004c4b40
W 2 00000064
R 2 00000064
W 0 fffffffe
R 0 00000000
R 3 00000000
R 8 00000000
R c 00000000
W 0 00000003
R 0 00000001
D 150
N 9
R 0 00000000
D 50
N 0
W 2 000003e8
W 0 00000001
D 60
W 0 00000000
M 6
D 100
N 0
W 1 00000000
D 40
W 0 00000001
D 60
N 0
R 0 00000001
W 0 00000000
W 9 ffffffff
R 4 00000000
W 4 1234a5a5
L a5a5
W 5 00000f00
L afa5
R 5 0000afa5
W 6 000000a5
L af00
H 4 00003c3c
L 3c3c
W 5 00000003
L 3c3f
R 4 00003c3f

//--- tb.f
logic/periph_pkg.sv
logic/periph_bus.sv
logic/tone_divider.sv
logic/buzzer.sv
logic/led_port.sv
logic/periph_top.sv
verif/periph_checker.sv
verif/periph_sva.sv
verif/periph_tb.sv

//--- Bender.yml
package:
  name: periph

sources:
  - files:
      - logic/periph_pkg.sv
      - logic/periph_bus.sv
      - logic/tone_divider.sv
      - logic/buzzer.sv
      - logic/led_port.sv
      - logic/periph_top.sv
  - target: test
    files:
      - verif/periph_checker.sv
      - verif/periph_sva.sv
      - verif/periph_tb.sv
